//--- design/motion_defines.svh
`ifndef MOTION_DEFINES_SVH
`define MOTION_DEFINES_SVH

// Axis and buffer sizing
`define MOTOR_COUNT 2
`define BUFFER_DEPTH 2

// Datapath widths
`define MOVE_DURATION_BITS 32
`define RATE_BITS 64

// 40 gives a 400 kHz tick from a 16 MHz clock
`define DEFAULT_CLOCK_DIVISOR 8'd40

// API version bytes reported by the version command
`define VERSION_MAJOR 8'h01
`define VERSION_MINOR 8'h02
`define VERSION_PATCH 8'h00
`define VERSION_DEVEL 8'h00

`endif

//--- design/cmd_pkg.sv
package cmd_pkg;

  // Command byte in the top of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,  // Multi-word move
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_MOTOR_BRAKE      = 8'h0b,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_STEPPER_FAULT    = 8'h50,
    CMD_API_VERSION      = 8'hfe
  } cmd_code_t;

  // First word of every message
  typedef struct packed {
    cmd_code_t   cmd;      // Bits 63:56
    logic [7:0]  motor;    // Axis index for per-axis commands
    logic [47:0] payload;  // Masks, divisor or dir bits in the low end
  } header_word_t;

  // One bus word, seen as a header or as plain data
  typedef union packed {
    header_word_t hdr;
    logic [63:0]  raw;     // Data words and responses
  } bus_word_t;

endpackage

//--- design/motion_pkg.sv
`include "motion_defines.svh"

package motion_pkg;

  // Slot in the move buffer
  typedef logic [$clog2(`BUFFER_DEPTH)-1:0] buf_index_t;

  // Move length in DDA ticks
  typedef logic [`MOVE_DURATION_BITS-1:0] duration_t;

  // Increment, increment-increment and accumulator
  typedef logic [`RATE_BITS-1:0] rate_t;

  // One bit per axis
  typedef logic [`MOTOR_COUNT-1:0] axis_mask_t;

endpackage

//--- design/axis_dda.sv
`timescale 1ns/1ns

module axis_dda (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              dda_tick,
  input  logic              loading_move,
  input  logic              executing_move,
  input  motion_pkg::rate_t increment,
  input  motion_pkg::rate_t increment2,
  output logic              step
);

  motion_pkg::rate_t rate;
  motion_pkg::rate_t accum;
  motion_pkg::rate_t accum_next;
  logic              carry;

  assign {carry, accum_next} = {1'b0, accum} + {1'b0, rate};  // Unsigned add

  always_ff @(posedge CLK) begin
    if (resetn) begin
      rate  <= '0;
      accum <= '0;
      step  <= 1'b0;
    end else begin
      step <= 1'b0;
      if (loading_move) begin
        accum <= '0;
        rate  <= increment;
      end else if (executing_move && dda_tick) begin
        accum <= accum_next;
        rate  <= rate + increment2;  // Acceleration term
        step  <= carry;              // One pulse per wrap
      end
    end
  end

endmodule

//--- design/command_decoder.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module command_decoder (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  cmd_pkg::bus_word_t                     word_data,
  input  logic                                   word_received,
  input  motion_pkg::axis_mask_t                 fault_n,
  output cmd_pkg::bus_word_t                     word_send_data,
  output motion_pkg::axis_mask_t                 enable,
  output motion_pkg::axis_mask_t                 brake,
  output logic [7:0]                             clock_divisor,
  output logic                                   wr_en,
  output motion_pkg::buf_index_t                 wr_slot,
  output motion_pkg::axis_mask_t                 wr_dir,
  output motion_pkg::duration_t                  wr_duration,
  output motion_pkg::rate_t [`MOTOR_COUNT-1:0]   wr_increment,
  output motion_pkg::rate_t [`MOTOR_COUNT-1:0]   wr_increment2,
  output logic                                   commit
);

  // Header, duration, then one increment pair per axis
  localparam int LAST_WORD = 2 * `MOTOR_COUNT + 1;

  logic [1:0] word_received_r;
  logic [7:0] message_header;
  logic [7:0] message_word_count;
  logic       word_accept;
  logic       awaiting_more_words;
  logic       move_header;

  assign word_accept         = (word_received_r == 2'b01);  // Rising edge
  assign awaiting_more_words = (message_header == cmd_pkg::CMD_COORDINATED_STEP);
  assign move_header         = word_accept && !awaiting_more_words &&
                               (word_data.hdr.cmd == cmd_pkg::CMD_COORDINATED_STEP);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_r    <= 2'b00;
      word_send_data     <= '0;
      enable             <= '0;
      brake              <= '0;
      clock_divisor      <= `DEFAULT_CLOCK_DIVISOR;
      message_header     <= 8'h00;
      message_word_count <= 8'h00;
      wr_slot            <= '0;
      wr_en              <= 1'b0;
      commit             <= 1'b0;
    end else begin
      word_received_r <= {word_received_r[0], word_received};
      wr_en           <= 1'b0;
      commit          <= 1'b0;
      if (commit) wr_slot <= wr_slot + 1'b1;  // Next free slot

      if (word_accept) begin
        word_send_data <= '0;
        if (!awaiting_more_words) begin
          message_header     <= word_data.hdr.cmd;
          message_word_count <= 8'd1;
          case (word_data.hdr.cmd)
            cmd_pkg::CMD_COORDINATED_STEP: wr_en <= 1'b1;  // Dir bits staged below
            cmd_pkg::CMD_MOTOR_ENABLE: enable <= word_data.hdr.payload[`MOTOR_COUNT-1:0];
            cmd_pkg::CMD_MOTOR_BRAKE:  brake  <= word_data.hdr.payload[`MOTOR_COUNT-1:0];
            cmd_pkg::CMD_CLK_DIVISOR:  clock_divisor <= word_data.hdr.payload[7:0];
            cmd_pkg::CMD_STEPPER_FAULT: begin
              word_send_data.raw[`MOTOR_COUNT-1:0] <= fault_n;
            end
            cmd_pkg::CMD_API_VERSION: begin
              word_send_data.raw[7:0]   <= `VERSION_PATCH;
              word_send_data.raw[15:8]  <= `VERSION_MINOR;
              word_send_data.raw[23:16] <= `VERSION_MAJOR;
              word_send_data.raw[31:24] <= `VERSION_DEVEL;
            end
            default: ;  // Unknown code answers zero
          endcase
        end else begin
          // Move data word, response stays zero
          message_word_count <= message_word_count + 8'd1;
          wr_en              <= 1'b1;
          if (message_word_count == 8'(LAST_WORD)) begin
            commit             <= 1'b1;
            message_header     <= 8'h00;
            message_word_count <= 8'h00;
          end
        end
      end
    end
  end

  // Entry staging, copied into the buffer on each wr_en
  always_ff @(posedge CLK) begin
    if (move_header) wr_dir <= word_data.hdr.payload[`MOTOR_COUNT-1:0];
    if (word_accept && awaiting_more_words) begin
      if (message_word_count == 8'd1) begin
        wr_duration <= word_data.raw[`MOVE_DURATION_BITS-1:0];
      end
      for (int n = 0; n < `MOTOR_COUNT; n++) begin
        if (message_word_count == 8'(2 * n + 2)) wr_increment[n]  <= word_data.raw;
        if (message_word_count == 8'(2 * n + 3)) wr_increment2[n] <= word_data.raw;
      end
    end
  end

endmodule

//--- design/move_buffer.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module move_buffer (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   wr_en,
  input  motion_pkg::buf_index_t                 wr_slot,
  input  motion_pkg::axis_mask_t                 wr_dir,
  input  motion_pkg::duration_t                  wr_duration,
  input  motion_pkg::rate_t [`MOTOR_COUNT-1:0]   wr_increment,
  input  motion_pkg::rate_t [`MOTOR_COUNT-1:0]   wr_increment2,
  input  logic                                   commit,
  input  motion_pkg::buf_index_t                 moveind,
  output logic [`BUFFER_DEPTH-1:0]               stepready,
  output motion_pkg::axis_mask_t                 rd_dir,
  output motion_pkg::duration_t                  rd_duration,
  output motion_pkg::rate_t [`MOTOR_COUNT-1:0]   rd_increment,
  output motion_pkg::rate_t [`MOTOR_COUNT-1:0]   rd_increment2
);

  motion_pkg::axis_mask_t               dir_mem       [`BUFFER_DEPTH];
  motion_pkg::duration_t                duration_mem  [`BUFFER_DEPTH];
  motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr_mem      [`BUFFER_DEPTH];
  motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr2_mem     [`BUFFER_DEPTH];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      stepready <= '0;
      for (int s = 0; s < `BUFFER_DEPTH; s++) begin
        dir_mem[s]      <= '0;
        duration_mem[s] <= '0;
        incr_mem[s]     <= '0;
        incr2_mem[s]    <= '0;
      end
    end else begin
      if (wr_en) begin
        dir_mem[wr_slot]      <= wr_dir;
        duration_mem[wr_slot] <= wr_duration;
        incr_mem[wr_slot]     <= wr_increment;
        incr2_mem[wr_slot]    <= wr_increment2;
      end
      // Toggle hands the slot to the sequencer
      if (commit) stepready[wr_slot] <= ~stepready[wr_slot];
    end
  end

  assign rd_dir        = dir_mem[moveind];
  assign rd_duration   = duration_mem[moveind];
  assign rd_increment  = incr_mem[moveind];
  assign rd_increment2 = incr2_mem[moveind];

endmodule

//--- design/move_sequencer.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module move_sequencer (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic [7:0]               clock_divisor,
  input  logic [`BUFFER_DEPTH-1:0] stepready,
  input  motion_pkg::duration_t    duration,
  output motion_pkg::buf_index_t   moveind,
  output logic                     dda_tick,
  output logic                     loading_move,
  output logic                     executing_move,
  output logic                     move_done,
  output logic                     buffer_dtr
);

  logic [7:0]               tick_count;
  logic [7:0]               tick_period;
  logic [`BUFFER_DEPTH-1:0] seen;        // Slots already played back
  motion_pkg::duration_t    move_count;
  logic                     last_tick;

  assign tick_period = (clock_divisor == 8'd0) ? 8'd1 : clock_divisor;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_count <= 8'd0;
      dda_tick   <= 1'b0;
    end else if (tick_count >= tick_period - 8'd1) begin
      tick_count <= 8'd0;
      dda_tick   <= 1'b1;
    end else begin
      tick_count <= tick_count + 8'd1;
      dda_tick   <= 1'b0;
    end
  end

  // Zero duration ends on the first tick
  assign last_tick = (duration == '0) || (move_count == duration - 1'b1);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      seen           <= '0;
      moveind        <= '0;
      move_count     <= '0;
      loading_move   <= 1'b0;
      executing_move <= 1'b0;
      move_done      <= 1'b0;
    end else begin
      loading_move <= 1'b0;
      move_done    <= 1'b0;
      if (executing_move) begin
        if (dda_tick) begin
          move_count <= move_count + 1'b1;
          if (last_tick) begin
            executing_move <= 1'b0;
            move_done      <= 1'b1;
            seen[moveind]  <= ~seen[moveind];  // Release the slot
            moveind        <= moveind + 1'b1;
          end
        end
      end else if (loading_move) begin
        executing_move <= 1'b1;
      end else if (stepready[moveind] != seen[moveind]) begin
        loading_move <= 1'b1;                  // New move waiting
        move_count   <= '0;
      end
    end
  end

  // Some slot is not holding a pending move
  assign buffer_dtr = |(~(stepready ^ seen));

endmodule

//--- design/stepper_ctrl_top.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module stepper_ctrl_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  cmd_pkg::bus_word_t     word_data,
  input  logic                   word_received,
  output cmd_pkg::bus_word_t     word_send_data,
  input  motion_pkg::axis_mask_t fault_n,
  output motion_pkg::axis_mask_t step,
  output motion_pkg::axis_mask_t dir,
  output motion_pkg::axis_mask_t enable,
  output motion_pkg::axis_mask_t brake,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  logic [7:0]                           clock_divisor;
  logic                                 wr_en;
  logic                                 commit;
  motion_pkg::buf_index_t               wr_slot;
  motion_pkg::axis_mask_t               wr_dir;
  motion_pkg::duration_t                wr_duration;
  motion_pkg::rate_t [`MOTOR_COUNT-1:0] wr_increment;
  motion_pkg::rate_t [`MOTOR_COUNT-1:0] wr_increment2;

  logic [`BUFFER_DEPTH-1:0]             stepready;
  motion_pkg::buf_index_t               moveind;
  motion_pkg::duration_t                rd_duration;
  motion_pkg::rate_t [`MOTOR_COUNT-1:0] rd_increment;
  motion_pkg::rate_t [`MOTOR_COUNT-1:0] rd_increment2;

  logic dda_tick;
  logic loading_move;
  logic executing_move;

  command_decoder u_decoder (
    .CLK(CLK), .resetn(resetn),
    .word_data(word_data), .word_received(word_received), .fault_n(fault_n),
    .word_send_data(word_send_data), .enable(enable), .brake(brake),
    .clock_divisor(clock_divisor),
    .wr_en(wr_en), .wr_slot(wr_slot), .wr_dir(wr_dir), .wr_duration(wr_duration),
    .wr_increment(wr_increment), .wr_increment2(wr_increment2), .commit(commit)
  );

  move_buffer u_buffer (
    .CLK(CLK), .resetn(resetn),
    .wr_en(wr_en), .wr_slot(wr_slot), .wr_dir(wr_dir), .wr_duration(wr_duration),
    .wr_increment(wr_increment), .wr_increment2(wr_increment2), .commit(commit),
    .moveind(moveind), .stepready(stepready),
    .rd_dir(dir), .rd_duration(rd_duration),  // Dir follows the active slot
    .rd_increment(rd_increment), .rd_increment2(rd_increment2)
  );

  move_sequencer u_sequencer (
    .CLK(CLK), .resetn(resetn),
    .clock_divisor(clock_divisor), .stepready(stepready), .duration(rd_duration),
    .moveind(moveind), .dda_tick(dda_tick), .loading_move(loading_move),
    .executing_move(executing_move), .move_done(move_done), .buffer_dtr(buffer_dtr)
  );

  // One DDA per axis
  for (genvar i = 0; i < `MOTOR_COUNT; i++) begin : g_axis
    axis_dda u_dda (
      .CLK(CLK), .resetn(resetn),
      .dda_tick(dda_tick), .loading_move(loading_move), .executing_move(executing_move),
      .increment(rd_increment[i]), .increment2(rd_increment2[i]),
      .step(step[i])
    );
  end

endmodule

//--- tests/tb_stepper_ctrl.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module tb_stepper_ctrl;

  localparam int CLK_PERIOD  = 8;
  localparam int WORD_CYCLES = 6;   // Four high, two low
  localparam int TOTAL_WORDS = 32;
  localparam int TOTAL_TICKS = 42;  // Sum of all move durations
  localparam int MAX_DIVISOR = 15;

  logic                   CLK = 1'b0;
  logic                   resetn;
  cmd_pkg::bus_word_t     word_data;
  logic                   word_received;
  cmd_pkg::bus_word_t     word_send_data;
  motion_pkg::axis_mask_t fault_n;
  motion_pkg::axis_mask_t step;
  motion_pkg::axis_mask_t dir;
  motion_pkg::axis_mask_t enable;
  motion_pkg::axis_mask_t brake;
  logic                   buffer_dtr;
  logic                   move_done;

  logic [31:0] rng_state = 32'h1968_11c1;
  integer      step_count [`MOTOR_COUNT] = '{default: 0};
  integer      done_count = 0;

  stepper_ctrl_top UUT (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Pulse counters
  always @(posedge CLK) begin
    for (int a = 0; a < `MOTOR_COUNT; a++) begin
      if (step[a]) step_count[a] <= step_count[a] + 1;
    end
    if (move_done) done_count <= done_count + 1;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Carries out of a 64-bit accumulator whose rate grows by incr2 per tick
  function automatic integer expected_steps(motion_pkg::rate_t incr, motion_pkg::rate_t incr2,
                                            int duration);
    logic [127:0] total;
    total = '0;
    for (int k = 0; k < duration; k++) begin
      total += 128'(incr) + 128'(k) * 128'(incr2);
    end
    return integer'(total >> 64);
  endfunction

  function automatic cmd_pkg::bus_word_t make_header(cmd_pkg::cmd_code_t cmd,
                                                     logic [47:0] payload);
    cmd_pkg::bus_word_t w;
    w.hdr.cmd     = cmd;
    w.hdr.motor   = 8'h00;
    w.hdr.payload = payload;
    return w;
  endfunction

  function automatic cmd_pkg::bus_word_t make_data(logic [63:0] value);
    cmd_pkg::bus_word_t w;
    w.raw = value;
    return w;
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(cmd_pkg::bus_word_t got, cmd_pkg::bus_word_t exp, string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s got %h expected %h", $time, what, got.raw, exp.raw));
  endtask

  task automatic check_mask(motion_pkg::axis_mask_t got, motion_pkg::axis_mask_t exp,
                            string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(integer got, integer exp, string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t ns: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic send_word(cmd_pkg::bus_word_t w);
    word_data     <= w;
    word_received <= 1'b1;
    repeat (4) @(posedge CLK);
    word_received <= 1'b0;
    repeat (2) @(posedge CLK);
  endtask

  // Header, duration, then increment and increment-increment per axis
  task automatic send_move(motion_pkg::axis_mask_t dirs, int duration,
                           motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr,
                           motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr2);
    send_word(make_header(cmd_pkg::CMD_COORDINATED_STEP, 48'(dirs)));
    send_word(make_data(64'(duration)));
    for (int a = 0; a < `MOTOR_COUNT; a++) begin
      send_word(make_data(incr[a]));
      send_word(make_data(incr2[a]));
    end
  endtask

  task automatic wait_moves(integer target);
    integer cycles;
    cycles = 0;
    while (done_count < target) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 4096) fail_run("Timed out waiting for move_done");
    end
  endtask

  task automatic expect_move(integer base [`MOTOR_COUNT],
                             motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr,
                             motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr2,
                             int duration, string what);
    for (int a = 0; a < `MOTOR_COUNT; a++) begin
      check_count(step_count[a] - base[a], expected_steps(incr[a], incr2[a], duration),
                  $sformatf("%s axis %0d steps", what, a));
    end
  endtask

  task automatic test_reset_state();
    check_mask(step, '0, "step after reset");
    check_mask(enable, '0, "enable after reset");
    check_mask(brake, '0, "brake after reset");
    check_bit(buffer_dtr, 1'b1, "buffer_dtr after reset");
    check_bit(move_done, 1'b0, "move_done after reset");
    check_word(word_send_data, make_data('0), "response after reset");
  endtask

  task automatic test_control_registers();
    motion_pkg::axis_mask_t en_mask;
    motion_pkg::axis_mask_t br_mask;
    en_mask = motion_pkg::axis_mask_t'(next_random());
    br_mask = motion_pkg::axis_mask_t'(next_random());
    send_word(make_header(cmd_pkg::CMD_MOTOR_ENABLE, 48'(en_mask)));
    send_word(make_header(cmd_pkg::CMD_MOTOR_BRAKE, 48'(br_mask)));
    check_mask(enable, en_mask, "enable mask");
    check_mask(brake, br_mask, "brake mask");
    en_mask = ~en_mask;  // Differs from the old enable and from brake
    if (en_mask == br_mask) en_mask = en_mask ^ motion_pkg::axis_mask_t'(1);
    send_word(make_header(cmd_pkg::CMD_MOTOR_ENABLE, 48'(en_mask)));
    check_mask(enable, en_mask, "enable mask rewritten");
    check_mask(brake, br_mask, "brake kept on enable write");
  endtask

  task automatic test_read_back();
    motion_pkg::axis_mask_t faults;
    send_word(make_header(cmd_pkg::CMD_API_VERSION, '0));
    check_word(word_send_data, make_data({32'h0, `VERSION_DEVEL, `VERSION_MAJOR,
               `VERSION_MINOR, `VERSION_PATCH}), "API version");
    faults = motion_pkg::axis_mask_t'(next_random());
    fault_n <= faults;
    send_word(make_header(cmd_pkg::CMD_STEPPER_FAULT, '0));
    check_word(word_send_data, make_data(64'(faults)), "stepper fault");
    send_word(make_header(cmd_pkg::cmd_code_t'(8'h77), '0));
    check_word(word_send_data, make_data('0), "unknown command");
  endtask

  task automatic test_single_move();
    motion_pkg::axis_mask_t               dirs;
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr;
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr2;
    integer                               base [`MOTOR_COUNT];
    integer                               done_base;
    dirs    = motion_pkg::axis_mask_t'(next_random());
    incr[0] = 64'd1 << 62;
    incr[1] = 64'd1 << 61;
    incr2   = '0;
    base      = step_count;
    done_base = done_count;
    send_word(make_header(cmd_pkg::CMD_CLK_DIVISOR, 48'(next_random() % 5)));  // 0 acts as 1
    send_move(dirs, 16, incr, incr2);
    check_mask(dir, dirs, "dir during move");
    wait_moves(done_base + 1);
    expect_move(base, incr, incr2, 16, "single move");
    repeat (8) @(posedge CLK);
    check_count(done_count - done_base, 1, "move_done pulses");
  endtask

  task automatic test_acceleration();
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr;
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr2;
    integer                               base [`MOTOR_COUNT];
    incr     = '0;
    incr2    = '0;
    incr2[0] = 64'd1 << 60;  // Rate ramps from zero
    base = step_count;
    send_move(motion_pkg::axis_mask_t'(next_random()), 8, incr, incr2);
    wait_moves(done_count + 1);
    expect_move(base, incr, incr2, 8, "accelerating move");
  endtask

  task automatic test_buffering();
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr_a;
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr_b;
    motion_pkg::rate_t [`MOTOR_COUNT-1:0] incr2;
    integer                               base [`MOTOR_COUNT];
    integer                               done_base;
    incr_a[0] = 64'd1 << 62;
    incr_a[1] = 64'd1 << 63;
    incr_b[0] = 64'd1 << 63;
    incr_b[1] = 64'd1 << 62;
    incr2     = '0;
    // Slow ticks keep the first move running while the second arrives
    send_word(make_header(cmd_pkg::CMD_CLK_DIVISOR, 48'(8 + next_random() % 8)));
    check_bit(buffer_dtr, 1'b1, "buffer_dtr before moves");
    base      = step_count;
    done_base = done_count;
    send_move(motion_pkg::axis_mask_t'(next_random()), 12, incr_a, incr2);
    send_move(motion_pkg::axis_mask_t'(next_random()), 6, incr_b, incr2);
    check_bit(buffer_dtr, 1'b0, "buffer_dtr with both slots full");
    wait_moves(done_base + 1);
    expect_move(base, incr_a, incr2, 12, "first buffered move");
    base = step_count;
    wait_moves(done_base + 2);
    expect_move(base, incr_b, incr2, 6, "second buffered move");
    check_bit(buffer_dtr, 1'b1, "buffer_dtr after both moves");
  endtask

  initial begin
    resetn        = 1'b1;
    word_data     = '0;
    word_received = 1'b0;
    fault_n       = '1;
    repeat (3) @(posedge CLK);
    resetn <= 1'b0;
    @(posedge CLK);
    test_reset_state();
    test_control_registers();
    test_read_back();
    test_single_move();
    test_acceleration();
    test_buffering();
    $display("TESTBENCH PASSED");
    $finish;
  end

  // Worst case of all words and moves at the slowest divisor, with margin
  initial begin
    #((3 + TOTAL_WORDS * WORD_CYCLES + TOTAL_TICKS * MAX_DIVISOR) * CLK_PERIOD * 4);
    fail_run("Watchdog expired before the tests finished");
  end

endmodule

//--- src.f
+incdir+design
design/cmd_pkg.sv
design/motion_pkg.sv
design/axis_dda.sv
design/command_decoder.sv
design/move_buffer.sv
design/move_sequencer.sv
design/stepper_ctrl_top.sv
tests/tb_stepper_ctrl.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	rm -f $(LOG)
	verilator --binary -Wno-fatal -f src.f --top-module tb_stepper_ctrl \
		-Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
